/* bench/exec_props.sv */
`timescale 1ns/10ps

module exec_props (
   input logic             i_clk,
   input logic             i_rst,
   input exec_pkg::state_e i_state,
   input logic             i_cmd_ready,
   input exec_pkg::cnt_t   i_cnt,
   input logic             i_done,
   input exec_pkg::trap_t  i_trap,
   input logic             i_rf_rreq,
   input logic             i_rf_ready
);
   import exec_pkg::*;

   // Outside IDLE, and once lowered, ready only comes back together with a done or trap pulse
   a_ready_idle: assert property (@(posedge i_clk) disable iff (i_rst)
      (!i_cmd_ready || (i_state != ST_IDLE)) |=>
         (!i_cmd_ready || i_done || i_trap.valid))
      else $error("command ready returned without a done or trap pulse");

   // Every pass ends with the counter wrapped back to zero, where it rests
   a_cnt_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_state == ST_IDLE) |-> (i_cnt == '0))
      else $error("bit counter is not at zero while IDLE");

   a_done_trap: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_done && i_trap.valid))
      else $error("done and trap are high in the same cycle");

   // The register file answers every read request exactly one cycle later
   a_rf_ready: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rf_rreq |=> i_rf_ready)
      else $error("register file ready did not follow its request");

endmodule

bind exec_state exec_props u_props (
   .i_clk       (i_clk),
   .i_rst       (i_rst),
   .i_state     (state),
   .i_cmd_ready (o_cmd_ready),
   .i_cnt       (o_cnt),
   .i_done      (o_done),
   .i_trap      (o_trap),
   .i_rf_rreq   (o_rf_rreq),
   .i_rf_ready  (i_rf_ready)
);

/* bench/exec_tb.sv */
`timescale 1ns/10ps
`include "exec_consts.svh"

module exec_tb;
   import exec_pkg::*;

   logic     i_clk;
   logic     i_rst;
   cmd_t     i_cmd;
   logic     i_cmd_valid;
   logic     o_cmd_ready;
   logic     i_irq;
   logic     o_done;
   trap_t    o_trap;
   reg_idx_t i_host_addr;
   word_t    o_host_data;

   integer seed;
   int     errors;
   int     checks;
   logic   timed_out;
   logic   irq_pending;
   word_t  model [`EXEC_NREGS];
   op_e    alu_ops [5];
   op_e    pass2_ops [5];

   exec_top u_dut (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cmd       (i_cmd),
      .i_cmd_valid (i_cmd_valid),
      .o_cmd_ready (o_cmd_ready),
      .i_irq       (i_irq),
      .o_done      (o_done),
      .o_trap      (o_trap),
      .i_host_addr (i_host_addr),
      .o_host_data (o_host_data)
   );

   always #10 i_clk = ~i_clk;

   task automatic compare_value(input string name, input word_t got, input word_t expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, expected);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR time=%0t %s", $time, msg);
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % $unsigned(n));
   endfunction

   // Sign boundaries show up often so compares and arithmetic shifts see them
   function automatic word_t pick_word();
      word_t w;
      case (rand_below(8))
         0:       w = 32'h8000_0000;
         1:       w = 32'h7fff_ffff;
         2:       w = 32'hffff_ffff;
         3:       w = 32'h0000_0000;
         4:       w = 32'h0000_0001;
         default: w = $random(seed);
      endcase
      return w;
   endfunction

   // Reference results follow the RISC-V definition of each operation
   function automatic word_t expected_result(input op_e op, input word_t a, input word_t b);
      logic [4:0] sh;
      word_t      r;
      sh = b[4:0];
      case (op)
         OP_ADD:  r = a + b;
         OP_SUB:  r = a - b;
         OP_AND:  r = a & b;
         OP_OR:   r = a | b;
         OP_XOR:  r = a ^ b;
         OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
         OP_SLL:  r = a << sh;
         OP_SRL:  r = a >> sh;
         OP_SRA:  r = $signed(a) >>> sh;
         default: r = '0;
      endcase
      return r;
   endfunction

   function automatic cmd_t make_cmd(input op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic use_imm, input word_t imm);
      cmd_t c;
      c.op      = op;
      c.rd      = rd;
      c.rs1     = rs1;
      c.rs2     = rs2;
      c.use_imm = use_imm;
      c.imm     = imm;
      return c;
   endfunction

   task automatic check_registers();
      for (int i = 0; i < `EXEC_NREGS; i++) begin
         @(negedge i_clk);
         i_host_addr = reg_idx_t'(i);
         #2;
         compare_value($sformatf("host_data[x%0d]", i), o_host_data, model[i]);
      end
   endtask

   // Issues one command and checks its completion pulse and the register file
   // An irq_at of zero or more raises i_irq for one cycle while the command runs
   task automatic run_cmd(input cmd_t c, input int irq_at);
      int     n;
      logic   exp_trap;
      cause_e exp_cause;
      word_t  b;
      word_t  res;
      if (timed_out) begin
         return;
      end
      exp_trap    = irq_pending | (c.op == OP_ECALL);
      exp_cause   = irq_pending ? CAUSE_IRQ : CAUSE_ECALL;
      b           = c.use_imm ? c.imm : model[c.rs2];
      res         = expected_result(c.op, model[c.rs1], b);
      irq_pending = 1'b0;

      @(negedge i_clk);
      i_cmd       = c;
      i_cmd_valid = 1'b1;
      n = 0;
      while (!o_cmd_ready && n < 100) begin
         @(negedge i_clk);
         n++;
      end
      if (!o_cmd_ready) begin
         report_error("command was not accepted within 100 cycles");
         i_cmd_valid = 1'b0;
         timed_out   = 1'b1;
         return;
      end
      @(negedge i_clk);
      i_cmd_valid = 1'b0;

      n = 0;
      while (!o_done && !o_trap.valid && n < 100) begin
         compare_value("o_cmd_ready", word_t'(o_cmd_ready), 32'd0);
         i_irq = (n == irq_at);
         if (n == irq_at) begin
            irq_pending = 1'b1;
         end
         @(negedge i_clk);
         n++;
      end
      i_irq = 1'b0;
      if (!o_done && !o_trap.valid) begin
         report_error("no done or trap pulse within 100 cycles of acceptance");
         timed_out = 1'b1;
         return;
      end

      if (exp_trap) begin
         compare_value("o_done", word_t'(o_done), 32'd0);
         compare_value("o_trap.valid", word_t'(o_trap.valid), 32'd1);
         compare_value("o_trap.cause", word_t'(o_trap.cause), word_t'(exp_cause));
         compare_value("o_trap.rd", word_t'(o_trap.rd), word_t'(c.rd));
      end else begin
         compare_value("o_done", word_t'(o_done), 32'd1);
         compare_value("o_trap.valid", word_t'(o_trap.valid), 32'd0);
         if (c.rd != '0) begin
            model[c.rd] = res;
         end
      end

      // Completion pulses last a single cycle
      @(negedge i_clk);
      compare_value("o_done", word_t'(o_done), 32'd0);
      compare_value("o_trap.valid", word_t'(o_trap.valid), 32'd0);
      check_registers();
   endtask

   task automatic load_reg(input reg_idx_t rd, input word_t value);
      run_cmd(make_cmd(OP_ADD, rd, '0, '0, 1'b1, value), -1);
   endtask

   function automatic reg_idx_t rand_reg();
      return reg_idx_t'(rand_below(`EXEC_NREGS));
   endfunction

   initial begin
      op_e op;
      seed        = 32'h8e98cd9c;
      i_clk       = 1'b0;
      i_rst       = 1'b1;
      i_cmd       = '0;
      i_cmd_valid = 1'b0;
      i_irq       = 1'b0;
      i_host_addr = '0;
      errors      = 0;
      checks      = 0;
      timed_out   = 1'b0;
      irq_pending = 1'b0;
      alu_ops     = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
      pass2_ops   = '{OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA};
      for (int i = 0; i < `EXEC_NREGS; i++) begin
         model[i] = '0;
      end

      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;

      compare_value("o_cmd_ready", word_t'(o_cmd_ready), 32'd1);
      compare_value("o_done", word_t'(o_done), 32'd0);
      compare_value("o_trap.valid", word_t'(o_trap.valid), 32'd0);
      check_registers();

      // Single pass operations on random registers and immediates
      for (int r = 1; r < `EXEC_NREGS; r++) begin
         load_reg(reg_idx_t'(r), pick_word());
      end
      load_reg('0, 32'h1234_5678);
      for (int k = 0; k < 200; k++) begin
         op = alu_ops[rand_below(5)];
         run_cmd(make_cmd(op, rand_reg(), rand_reg(), rand_reg(), rand_below(2) == 1,
                          pick_word()), -1);
      end

      // Compares and shifts over every pairing of the boundary words
      load_reg(3'd1, 32'h8000_0000);
      load_reg(3'd2, 32'h7fff_ffff);
      load_reg(3'd3, 32'hffff_ffff);
      load_reg(3'd4, 32'h0000_0001);
      for (int k = 0; k < 5; k++) begin
         for (int a = 1; a <= 4; a++) begin
            for (int s = 1; s <= 4; s++) begin
               run_cmd(make_cmd(pass2_ops[k], 3'd5, reg_idx_t'(a), reg_idx_t'(s), 1'b0,
                                '0), -1);
            end
         end
      end
      for (int k = 2; k < 5; k++) begin
         for (int a = 1; a <= 4; a++) begin
            run_cmd(make_cmd(pass2_ops[k], 3'd6, reg_idx_t'(a), '0, 1'b1, 32'd0), -1);
            run_cmd(make_cmd(pass2_ops[k], 3'd7, reg_idx_t'(a), '0, 1'b1, 32'd31), -1);
         end
      end
      for (int k = 0; k < 60; k++) begin
         op = pass2_ops[rand_below(5)];
         run_cmd(make_cmd(op, rand_reg(), rand_reg(), rand_reg(), rand_below(2) == 1,
                          pick_word()), -1);
      end

      // Environment calls leave the registers alone
      for (int k = 0; k < 4; k++) begin
         run_cmd(make_cmd(OP_ECALL, rand_reg(), rand_reg(), rand_reg(), 1'b0, '0), -1);
      end

      // An interrupt taken during one command turns the next one into a trap
      run_cmd(make_cmd(OP_ADD, 3'd2, 3'd3, 3'd4, 1'b0, '0), 5);
      run_cmd(make_cmd(OP_SUB, 3'd5, 3'd1, 3'd2, 1'b0, '0), -1);
      run_cmd(make_cmd(OP_XOR, 3'd6, 3'd1, 3'd3, 1'b0, '0), -1);
      run_cmd(make_cmd(OP_SRA, 3'd7, 3'd1, 3'd0, 1'b1, 32'd4), 20);
      run_cmd(make_cmd(OP_SLT, 3'd3, 3'd1, 3'd2, 1'b0, '0), -1);
      run_cmd(make_cmd(OP_SLL, 3'd4, 3'd2, 3'd0, 1'b1, 32'd31), -1);

      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* hw/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Width of an architectural register and of every operand word
`define EXEC_XLEN 32

// Number of registers in the serial register file
`define EXEC_NREGS 8

// Width of the bit position counter
// One pass walks all EXEC_XLEN bit positions
`define EXEC_CNT_W 5

`endif

/* hw/exec_pkg.sv */
`include "exec_consts.svh"

package exec_pkg;

   typedef logic [$clog2(`EXEC_NREGS)-1:0] reg_idx_t;
   typedef logic [`EXEC_XLEN-1:0]          word_t;
   typedef logic [`EXEC_CNT_W-1:0]         cnt_t;

   // Decoded operations accepted on the command channel
   typedef enum logic [3:0] {
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
      OP_ECALL
   } op_e;

   // Pass sequencer states
   typedef enum logic [1:0] {
      ST_IDLE, ST_INIT, ST_RUN, ST_TRAP
   } state_e;

   typedef enum logic {
      CAUSE_IRQ, CAUSE_ECALL
   } cause_e;

   typedef struct packed {
      op_e      op;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      logic     use_imm;
      word_t    imm;
   } cmd_t;

   // The rd field names the destination of the command that was discarded
   typedef struct packed {
      logic     valid;
      cause_e   cause;
      reg_idx_t rd;
   } trap_t;

endpackage

/* hw/exec_state.sv */
`timescale 1ns/10ps
`include "exec_consts.svh"

module exec_state (
   input  logic            i_clk,
   input  logic            i_rst,
   input  exec_pkg::cmd_t  i_cmd,
   input  logic            i_cmd_valid,
   output logic            o_cmd_ready,
   input  logic            i_irq,
   input  logic            i_rf_ready,
   output logic            o_rf_rreq,
   output exec_pkg::cmd_t  o_cmd_q,
   output logic            o_init,
   output logic            o_cnt_en,
   output exec_pkg::cnt_t  o_cnt,
   output logic            o_rf_wen,
   output logic            o_shamt_en,
   input  logic            i_lt,
   output logic            o_slt_bit,
   output logic            o_done,
   output exec_pkg::trap_t o_trap
);
   import exec_pkg::*;

   localparam int SHAMT_W = $clog2(`EXEC_XLEN);

   state_e     state;
   logic [3:0] cnt_r;
   logic       cnt_done;
   logic       cmd_busy;
   logic       accept;
   logic       accept_q;
   logic       stage_two_req;
   logic       stage_two_pending;
   logic       two_stage_op;
   logic       irq_sync;
   logic       pending_irq;
   logic       trap_valid;

   assign o_cmd_ready = (state == ST_IDLE) & ~cmd_busy;
   assign accept      = i_cmd_valid & o_cmd_ready;

   assign o_cnt_en   = (state != ST_IDLE);
   assign o_init     = (state == ST_INIT);
   assign o_rf_wen   = (state == ST_RUN);
   assign o_shamt_en = o_init & (o_cnt < cnt_t'(SHAMT_W));

   // The register file is asked for operands after acceptance and again before stage two
   assign o_rf_rreq = accept_q | stage_two_req;

   // Compares and shifts need a first pass to gather their operand information
   assign two_stage_op = o_cmd_q.op inside {OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA};

   always_comb begin
      o_trap.valid = trap_valid;
      o_trap.cause = pending_irq ? CAUSE_IRQ : CAUSE_ECALL;
      o_trap.rd    = o_cmd_q.rd;
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_cmd_q <= i_cmd;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state             <= ST_IDLE;
         o_cnt             <= '0;
         cnt_r             <= 4'b0001;
         cnt_done          <= 1'b0;
         cmd_busy          <= 1'b0;
         accept_q          <= 1'b0;
         stage_two_req     <= 1'b0;
         stage_two_pending <= 1'b0;
         irq_sync          <= 1'b0;
         pending_irq       <= 1'b0;
         o_slt_bit         <= 1'b0;
         o_done            <= 1'b0;
         trap_valid        <= 1'b0;
      end else begin
         accept_q <= accept;

         o_cnt <= o_cnt + cnt_t'(o_cnt_en);
         if (o_cnt_en) begin
            cnt_r <= {cnt_r[2:0], cnt_r[3]};
         end
         // Raised one cycle early so it is high during the last bit position
         cnt_done <= (&o_cnt[`EXEC_CNT_W-1:2]) & cnt_r[2];

         // Strobe for the first IDLE cycle after an INIT pass
         stage_two_req <= cnt_done & o_init;
         if (o_cnt_en) begin
            stage_two_pending <= o_init;
         end

         o_done     <= cnt_done & (state == ST_RUN);
         trap_valid <= cnt_done & (state == ST_TRAP);

         if (cnt_done & o_init) begin
            o_slt_bit <= i_lt;
         end

         if (accept) begin
            cmd_busy <= 1'b1;
         end else if (cnt_done & ~o_init) begin
            cmd_busy <= 1'b0;
         end

         // A request seen on the acceptance edge stays latched for the next command
         if (accept) begin
            pending_irq <= irq_sync;
            irq_sync    <= 1'b0;
         end
         if (i_irq) begin
            irq_sync <= 1'b1;
         end

         if (i_rf_ready & ~o_cnt_en) begin
            if (pending_irq | (o_cmd_q.op == OP_ECALL)) begin
               state <= ST_TRAP;
            end else if (two_stage_op & ~stage_two_pending) begin
               state <= ST_INIT;
            end else begin
               state <= ST_RUN;
            end
         end
         if (cnt_done) begin
            state <= ST_IDLE;
         end
      end
   end

endmodule

/* hw/exec_top.sv */
`timescale 1ns/10ps

module exec_top (
   input  logic               i_clk,
   input  logic               i_rst,
   input  exec_pkg::cmd_t     i_cmd,
   input  logic               i_cmd_valid,
   output logic               o_cmd_ready,
   input  logic               i_irq,
   output logic               o_done,
   output exec_pkg::trap_t    o_trap,
   input  exec_pkg::reg_idx_t i_host_addr,
   output exec_pkg::word_t    o_host_data
);
   import exec_pkg::*;

   cmd_t cmd_q;
   cnt_t cnt;
   logic rf_rreq;
   logic rf_ready;
   logic init;
   logic cnt_en;
   logic rf_wen;
   logic shamt_en;
   logic lt;
   logic slt_bit;
   logic rs1_bit;
   logic rs2_bit;
   logic b_bit;
   logic alu_bit;
   logic sh_bit;
   logic wbit;

   // Second operand comes from rs2 or from the held immediate
   assign b_bit = cmd_q.use_imm ? cmd_q.imm[cnt] : rs2_bit;

   always_comb begin
      case (cmd_q.op)
         OP_SLL, OP_SRL, OP_SRA: wbit = sh_bit;
         // Only bit 0 of a compare result can be set
         OP_SLT, OP_SLTU:        wbit = (cnt == '0) ? slt_bit : 1'b0;
         default:                wbit = alu_bit;
      endcase
   end

   exec_state u_state (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cmd       (i_cmd),
      .i_cmd_valid (i_cmd_valid),
      .o_cmd_ready (o_cmd_ready),
      .i_irq       (i_irq),
      .i_rf_ready  (rf_ready),
      .o_rf_rreq   (rf_rreq),
      .o_cmd_q     (cmd_q),
      .o_init      (init),
      .o_cnt_en    (cnt_en),
      .o_cnt       (cnt),
      .o_rf_wen    (rf_wen),
      .o_shamt_en  (shamt_en),
      .i_lt        (lt),
      .o_slt_bit   (slt_bit),
      .o_done      (o_done),
      .o_trap      (o_trap)
   );

   serial_rf u_rf (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rreq      (rf_rreq),
      .o_ready     (rf_ready),
      .i_rs1       (cmd_q.rs1),
      .i_rs2       (cmd_q.rs2),
      .i_rd        (cmd_q.rd),
      .i_cnt       (cnt),
      .i_wen       (rf_wen),
      .i_wbit      (wbit),
      .o_rs1_bit   (rs1_bit),
      .o_rs2_bit   (rs2_bit),
      .i_host_addr (i_host_addr),
      .o_host_data (o_host_data)
   );

   serial_alu u_alu (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_op     (cmd_q.op),
      .i_cnt_en (cnt_en),
      .i_init   (init),
      .i_cnt    (cnt),
      .i_a      (rs1_bit),
      .i_b      (b_bit),
      .o_bit    (alu_bit),
      .o_lt     (lt)
   );

   shift_buf u_shift (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_op       (cmd_q.op),
      .i_init     (init),
      .i_cnt_en   (cnt_en),
      .i_shamt_en (shamt_en),
      .i_cnt      (cnt),
      .i_a        (rs1_bit),
      .i_b        (b_bit),
      .o_bit      (sh_bit)
   );

endmodule

/* hw/serial_alu.sv */
`timescale 1ns/10ps
`include "exec_consts.svh"

module serial_alu (
   input  logic           i_clk,
   input  logic           i_rst,
   input  exec_pkg::op_e  i_op,
   input  logic           i_cnt_en,
   input  logic           i_init,
   input  exec_pkg::cnt_t i_cnt,
   input  logic           i_a,
   input  logic           i_b,
   output logic           o_bit,
   output logic           o_lt
);
   import exec_pkg::*;

   logic is_sub;
   logic b_eff;
   logic carry_q;
   logic carry_in;
   logic carry_out;
   logic sum;
   logic last_bit;
   logic a_lt_b;

   // Compares are computed as a subtraction
   assign is_sub = (i_op == OP_SUB) | (i_op == OP_SLT) | (i_op == OP_SLTU);
   assign b_eff  = i_b ^ is_sub;

   // The carry is preset on bit 0 so that sub forms a + ~b + 1
   assign carry_in  = (i_cnt == '0) ? is_sub : carry_q;
   assign sum       = i_a ^ b_eff ^ carry_in;
   assign carry_out = (i_a & b_eff) | (carry_in & (i_a ^ b_eff));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= carry_out;
      end
   end

   assign last_bit = (i_cnt == cnt_t'(`EXEC_XLEN - 1));

   // With differing signs the negative operand is the smaller one
   // Otherwise a missing final carry means a borrow
   assign a_lt_b = ((i_op == OP_SLT) & (i_a ^ i_b)) ? i_a : ~carry_out;
   assign o_lt   = i_init & last_bit & a_lt_b;

   always_comb begin
      case (i_op)
         OP_AND:  o_bit = i_a & i_b;
         OP_OR:   o_bit = i_a | i_b;
         OP_XOR:  o_bit = i_a ^ i_b;
         default: o_bit = sum;
      endcase
   end

endmodule

/* hw/serial_rf.sv */
`timescale 1ns/10ps
`include "exec_consts.svh"

module serial_rf (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_rreq,
   output logic               o_ready,
   input  exec_pkg::reg_idx_t i_rs1,
   input  exec_pkg::reg_idx_t i_rs2,
   input  exec_pkg::reg_idx_t i_rd,
   input  exec_pkg::cnt_t     i_cnt,
   input  logic               i_wen,
   input  logic               i_wbit,
   output logic               o_rs1_bit,
   output logic               o_rs2_bit,
   input  exec_pkg::reg_idx_t i_host_addr,
   output exec_pkg::word_t    o_host_data
);
   import exec_pkg::*;

   word_t regs [`EXEC_NREGS];

   // Architectural state starts from zero so the host sees a clean file after reset
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ready <= 1'b0;
         for (int i = 0; i < `EXEC_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         o_ready <= i_rreq;
         // Register 0 is hardwired to zero
         if (i_wen && (i_rd != '0)) begin
            regs[i_rd][i_cnt] <= i_wbit;
         end
      end
   end

   // Operand bits stream out LSB first as the counter advances
   assign o_rs1_bit = regs[i_rs1][i_cnt];
   assign o_rs2_bit = regs[i_rs2][i_cnt];

   assign o_host_data = regs[i_host_addr];

endmodule

/* hw/shift_buf.sv */
`timescale 1ns/10ps
`include "exec_consts.svh"

module shift_buf (
   input  logic           i_clk,
   input  logic           i_rst,
   input  exec_pkg::op_e  i_op,
   input  logic           i_init,
   input  logic           i_cnt_en,
   input  logic           i_shamt_en,
   input  exec_pkg::cnt_t i_cnt,
   input  logic           i_a,
   input  logic           i_b,
   output logic           o_bit
);
   import exec_pkg::*;

   localparam int SHAMT_W = $clog2(`EXEC_XLEN);

   word_t              shreg;
   logic [SHAMT_W-1:0] shamt;
   logic [SHAMT_W:0]   src_up;
   logic               fill;

   // The rs1 word enters from the top during INIT and ends up in place after 32 cycles
   always_ff @(posedge i_clk) begin
      if (i_init & i_cnt_en) begin
         shreg <= {i_a, shreg[`EXEC_XLEN-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         shamt <= '0;
      end else if (i_shamt_en) begin
         shamt <= {i_b, shamt[SHAMT_W-1:1]};
      end
   end

   // Source position for right shifts with one extra bit to flag overrun
   assign src_up = {1'b0, i_cnt} + {1'b0, shamt};
   assign fill   = (i_op == OP_SRA) & shreg[`EXEC_XLEN-1];

   always_comb begin
      if (i_op == OP_SLL) begin
         o_bit = (i_cnt >= shamt) ? shreg[i_cnt - shamt] : 1'b0;
      end else begin
         o_bit = src_up[SHAMT_W] ? fill : shreg[src_up[SHAMT_W-1:0]];
      end
   end

endmodule

/* list.f */
+incdir+hw
hw/exec_pkg.sv
hw/exec_state.sv
hw/serial_rf.sv
hw/serial_alu.sv
hw/shift_buf.sv
hw/exec_top.sv
bench/exec_props.sv
bench/exec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module exec_tb \
   --Mdir "$BUILD_DIR" -o exec_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/exec_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
   exit 1
fi
exit 0
